//--- project.f
+incdir+tb
hdl/rv_pipe_pkg.sv
hdl/rv_pipe_data.sv
hdl/rv_credit_counter.sv
hdl/rv_hazard_unit.sv
hdl/rv_pipe_top.sv
tb/rv_pipe_tb.sv

//--- Makefile
# Verilator build for the pipeline shell

VERILATOR  ?= verilator
TOP        ?= rv_pipe_tb
RTL_TOP    ?= rv_pipe_top
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing
JOBS       ?= 4

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/rv_pipe_tests.svh
// Random R-type instruction that is never a load
function automatic fetch_slot_t random_slot();
  fetch_slot_t s;
  logic [31:0] pc_bits;
  logic [31:0] op_bits;
  pc_bits = rand_bits(30);
  op_bits = rand_bits(25);
  s.valid = 1'b1;
  s.pc    = {pc_bits[29:0], 2'b00};
  s.instr = {op_bits[24:0], 7'b0110011};
  return s;
endfunction

function automatic fetch_slot_t make_slot(input reg_idx_t rs2, input reg_idx_t rs1,
                                          input reg_idx_t rd, input logic [6:0] opc);
  fetch_slot_t s;
  logic [31:0] pc_bits;
  pc_bits = rand_bits(30);
  s.valid = 1'b1;
  s.pc    = {pc_bits[29:0], 2'b00};
  s.instr = {7'b0000000, rs2, rs1, 3'b010, rd, opc};
  return s;
endfunction

// Offers one slot until accepted or max_wait cycles of back-pressure
task automatic send_slot(input fetch_slot_t s, input int max_wait,
                         output int waits, output bit accepted);
  waits    = 0;
  accepted = 1'b0;
  @(negedge clk);
  in_slot_i  = s;
  in_valid_i = 1'b1;
  while (!accepted && waits <= max_wait) begin
    @(posedge clk);
    if (in_ready_o) begin
      accepted = 1'b1;
    end else begin
      waits++;
    end
  end
  if (!accepted) begin
    @(negedge clk);
    in_valid_i = 1'b0;
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) begin
    @(negedge clk);
    in_valid_i = 1'b0;
  end
endtask

// Lets every slot out and every credit come home
task automatic drain_pipe();
  int n;
  n = 0;
  auto_return = 1'b1;
  idle_cycles(1);
  while (scoreboard.size() != 0 || sent_total != returned_total) begin
    @(posedge clk);
    n++;
    if (n > 100) begin
      report_error("pipeline did not drain");
    end
  end
  idle_cycles(2);
endtask

task automatic test_reset_idle();
  repeat (8) begin
    @(posedge clk);
    check_ready(1'b1);
    if (out_valid_o !== 1'b0) begin
      report_error("out_valid_o high with no input");
    end
  end
endtask

task automatic test_streaming();
  int waits;
  bit acc;
  check_latency = 1'b1;
  for (int i = 0; i < 40; i++) begin
    send_slot(random_slot(), 0, waits, acc);
    if (!acc) begin
      report_error("streaming slot was not accepted at once");
    end
  end
  drain_pipe();
  check_latency = 1'b0;
endtask

task automatic load_use_pair(input reg_idx_t rd, input int expected_waits,
                             input ctrl_state_t expected_state);
  int waits;
  bit acc;
  send_slot(make_slot(5'd3, 5'd7, rd, OPC_LOAD), 0, waits, acc);
  if (!acc) begin
    report_error("load slot was not accepted at once");
  end
  send_slot(make_slot(5'd9, rd, 5'd12, 7'b0110011), 0, waits, acc);
  if (!acc) begin
    report_error("dependent slot was not accepted at once");
  end
  // Stall shows up to the slot offered after the dependent one
  send_slot(random_slot(), 5, waits, acc);
  if (!acc || waits != expected_waits) begin
    report_error($sformatf("load-use wait was %0d cycles, expected %0d",
                 waits, expected_waits));
  end
  // Decision of the cycle before this acceptance
  check_state(rv_pipe_top_inst.ctrl_state, expected_state);
  send_slot(random_slot(), 0, waits, acc);
  drain_pipe();
endtask

task automatic test_load_use();
  load_use_pair(5'd5, 1, LOAD_STALL);
  load_use_pair(5'd0, 0, RUN);
endtask

task automatic test_credit_backpressure();
  int waits;
  bit acc;
  int sent_before;
  int accepted_n;
  sent_before = sent_total;
  accepted_n  = 0;
  auto_return = 1'b0;
  // Credits plus the three stage registers fill up and the next slot is refused
  for (int i = 0; i < int'(CREDITS) + 4; i++) begin
    send_slot(random_slot(), 12, waits, acc);
    if (acc) begin
      accepted_n++;
    end
  end
  if (accepted_n != int'(CREDITS) + 3) begin
    report_error($sformatf("%0d slots accepted under back-pressure, expected %0d",
                 accepted_n, int'(CREDITS) + 3));
  end
  repeat (10) begin
    @(negedge clk);
    in_valid_i = 1'b0;
    @(posedge clk);
    check_ready(1'b0);
    check_state(rv_pipe_top_inst.ctrl_state, CREDIT_STALL);
  end
  if (sent_total - sent_before != int'(CREDITS)) begin
    report_error($sformatf("%0d slots delivered without returns, expected %0d",
                 sent_total - sent_before, int'(CREDITS)));
  end
  if (scoreboard.size() != 3) begin
    report_error("slots held in the stalled pipe were lost");
  end
  drain_pipe();
endtask

task automatic test_redirect();
  int waits;
  bit acc;
  int sent_before;
  sent_before = sent_total;
  for (int i = 0; i < 12; i++) begin
    send_slot(random_slot(), 0, waits, acc);
    if (i == 5) begin
      @(negedge clk);
      in_valid_i = 1'b0;
      redirect_i = 1'b1;
      @(posedge clk);
      check_ready(1'b0);
      @(negedge clk);
      redirect_i = 1'b0;
    end
  end
  drain_pipe();
  if (sent_total - sent_before != 11) begin
    report_error($sformatf("%0d slots delivered around redirect, expected 11",
                 sent_total - sent_before));
  end
endtask

//--- tb/rv_pipe_tb.sv
`timescale 1ns/1ns

module rv_pipe_tb import rv_pipe_pkg::*; ();

  // One edge per stage register from acceptance to send
  localparam int PIPE_LATENCY = 3;
  localparam int TEST_CYCLES  = 700;
  localparam int CLK_PERIOD   = 4;

  logic        clk;
  logic        rst_n;
  fetch_slot_t in_slot_i;
  logic        in_valid_i;
  logic        in_ready_o;
  logic        redirect_i;
  dec_slot_t   out_slot_o;
  logic        out_valid_o;
  logic        credit_return_i;

  dec_slot_t   scoreboard[$];
  int          accept_cycle[$];
  int          cycle;
  int          last_accept;
  int          sent_total;
  int          returned_total;
  bit          auto_return;
  bit          check_latency;
  logic [31:0] lfsr_state;

  rv_pipe_top rv_pipe_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_slot_i       (in_slot_i),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .redirect_i      (redirect_i),
    .out_slot_o      (out_slot_o),
    .out_valid_o     (out_valid_o),
    .credit_return_i (credit_return_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopping after first error");
  endtask

  function automatic string format_slot(input dec_slot_t s);
    return $sformatf("valid %b pc %h instr %h rd %0d rs1 %0d rs2 %0d ld %b",
                     s.valid, s.pc, s.instr, s.rd, s.rs1, s.rs2, s.is_load);
  endfunction

  task automatic check_slot(input dec_slot_t actual, input dec_slot_t expected);
    if (actual !== expected) begin
      report_error({"slot ", format_slot(actual), ", expected ", format_slot(expected)});
    end
  endtask

  task automatic check_credit(input credit_t actual, input credit_t expected);
    if (actual !== expected) begin
      report_error($sformatf("credit count %0d, expected %0d", actual, expected));
    end
  endtask

  task automatic check_ready(input logic expected);
    if (in_ready_o !== expected) begin
      report_error($sformatf("in_ready_o %b, expected %b", in_ready_o, expected));
    end
  endtask

  task automatic check_state(input ctrl_state_t actual, input ctrl_state_t expected);
    if (actual !== expected) begin
      report_error($sformatf("hazard state %0d, expected %0d", actual, expected));
    end
  endtask

  // Field positions follow the RV32 base encoding
  function automatic dec_slot_t expected_decode(input fetch_slot_t s);
    dec_slot_t d;
    d.valid   = 1'b1;
    d.pc      = s.pc;
    d.instr   = s.instr;
    d.rd      = s.instr[11:7];
    d.rs1     = s.instr[19:15];
    d.rs2     = s.instr[24:20];
    d.is_load = (s.instr[6:0] == 7'b0000011);
    return d;
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Scoreboard and credit bookkeeping on the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      cycle <= cycle + 1;
      check_credit(rv_pipe_top_inst.credit_count,
                   credit_t'(int'(CREDITS) - sent_total + returned_total));
      // Slot accepted on the previous edge is the wrong-path one
      if (redirect_i && scoreboard.size() > 0 && last_accept == cycle - 1) begin
        void'(scoreboard.pop_back());
        void'(accept_cycle.pop_back());
      end
      if (in_valid_i && in_ready_o) begin
        scoreboard.push_back(expected_decode(in_slot_i));
        accept_cycle.push_back(cycle);
        last_accept <= cycle;
      end
      if (out_valid_o) begin
        if (scoreboard.size() == 0) begin
          report_error("output slot delivered with nothing expected");
        end
        check_slot(out_slot_o, scoreboard.pop_front());
        if (check_latency && cycle - accept_cycle[0] != PIPE_LATENCY) begin
          report_error($sformatf("latency %0d, expected %0d",
                       cycle - accept_cycle[0], PIPE_LATENCY));
        end
        void'(accept_cycle.pop_front());
        sent_total <= sent_total + 1;
      end
      if (credit_return_i) begin
        returned_total <= returned_total + 1;
      end
    end
  end

  // Consumer returns one credit per cycle while any are owed
  always @(negedge clk) begin
    credit_return_i = rst_n && auto_return && (sent_total - returned_total > 0);
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD + 200);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  `include "rv_pipe_tests.svh"

  initial begin
    rst_n           = 1'b0;
    in_slot_i       = FETCH_IDLE;
    in_valid_i      = 1'b0;
    redirect_i      = 1'b0;
    credit_return_i = 1'b0;
    cycle           = 0;
    last_accept     = -10;
    sent_total      = 0;
    returned_total  = 0;
    auto_return     = 1'b1;
    check_latency   = 1'b0;
    lfsr_state      = 32'd93281;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset_idle();
    test_streaming();
    test_load_use();
    test_credit_backpressure();
    test_redirect();
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hdl/rv_pipe_top.sv
`timescale 1ns/1ns

module rv_pipe_top import rv_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  fetch_slot_t in_slot_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  logic        redirect_i,
  output dec_slot_t   out_slot_o,
  output logic        out_valid_o,
  input  logic        credit_return_i
);

  fetch_slot_t if_id_d;
  fetch_slot_t if_id_q;
  dec_slot_t   id_dec;
  dec_slot_t   id_ex_q;
  dec_slot_t   ex_out_q;

  logic        if_id_advance;
  logic        if_id_flush;
  logic        id_ex_advance;
  logic        id_ex_bubble;
  logic        ex_out_advance;
  logic        send;
  logic        credit_avail;

  // Observation points for waveforms and the testbench
  credit_t     credit_count;
  ctrl_state_t ctrl_state;

  // Handshake valid becomes the slot valid, an idle input enters as a bubble
  always_comb begin
    if_id_d       = in_slot_i;
    if_id_d.valid = in_valid_i;
  end

  rv_pipe_data #(
    .WIDTH    ($bits(fetch_slot_t)),
    .IDLE_VAL (FETCH_IDLE)
  ) if_id_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (if_id_advance),
    .flush_i   (if_id_flush),
    .bubble_i  (1'b0),
    .data_i    (if_id_d),
    .data_o    (if_id_q)
  );

  // Decode sits between IF/ID and ID/EX
  assign id_dec = rv_decode(if_id_q);

  rv_pipe_data #(
    .WIDTH    ($bits(dec_slot_t)),
    .IDLE_VAL (DEC_IDLE)
  ) id_ex_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (id_ex_advance),
    .flush_i   (1'b0),
    .bubble_i  (id_ex_bubble),
    .data_i    (id_dec),
    .data_o    (id_ex_q)
  );

  rv_pipe_data #(
    .WIDTH    ($bits(dec_slot_t)),
    .IDLE_VAL (DEC_IDLE)
  ) ex_out_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance_i (ex_out_advance),
    .flush_i   (1'b0),
    .bubble_i  (1'b0),
    .data_i    (id_ex_q),
    .data_o    (ex_out_q)
  );

  rv_hazard_unit rv_hazard_unit_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .id_slot_i        (id_dec),
    .ex_slot_i        (id_ex_q),
    .out_slot_valid_i (ex_out_q.valid),
    .credit_avail_i   (credit_avail),
    .redirect_i       (redirect_i),
    .if_id_advance_o  (if_id_advance),
    .if_id_flush_o    (if_id_flush),
    .id_ex_advance_o  (id_ex_advance),
    .id_ex_bubble_o   (id_ex_bubble),
    .ex_out_advance_o (ex_out_advance),
    .in_ready_o       (in_ready_o),
    .send_o           (send),
    .state_o          (ctrl_state)
  );

  rv_credit_counter rv_credit_counter_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .send_i          (send),
    .credit_return_i (credit_return_i),
    .credit_avail_o  (credit_avail),
    .count_o         (credit_count)
  );

  // A slot is delivered only in the cycle its credit is spent
  assign out_slot_o  = ex_out_q;
  assign out_valid_o = send;

endmodule

//--- hdl/rv_hazard_unit.sv
`timescale 1ns/1ns

module rv_hazard_unit import rv_pipe_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  dec_slot_t   id_slot_i,
  input  dec_slot_t   ex_slot_i,
  input  logic        out_slot_valid_i,
  input  logic        credit_avail_i,
  input  logic        redirect_i,
  output logic        if_id_advance_o,
  output logic        if_id_flush_o,
  output logic        id_ex_advance_o,
  output logic        id_ex_bubble_o,
  output logic        ex_out_advance_o,
  output logic        in_ready_o,
  output logic        send_o,
  output ctrl_state_t state_o
);

  logic        credit_stall;
  logic        load_use;
  ctrl_state_t state_d;
  ctrl_state_t state_q;

  // Output slot waits with nothing to pay for it
  assign credit_stall = out_slot_valid_i && !credit_avail_i;

  // Load in EX feeds a source of the instruction being decoded
  assign load_use = ex_slot_i.valid && ex_slot_i.is_load && (ex_slot_i.rd != '0) &&
                    id_slot_i.valid &&
                    ((ex_slot_i.rd == id_slot_i.rs1) || (ex_slot_i.rd == id_slot_i.rs2));

  assign send_o = out_slot_valid_i && credit_avail_i;

  always_comb begin
    if_id_advance_o  = 1'b0;
    if_id_flush_o    = 1'b0;
    id_ex_advance_o  = 1'b0;
    id_ex_bubble_o   = 1'b0;
    ex_out_advance_o = 1'b0;
    in_ready_o       = 1'b0;
    state_d          = RUN;
    if (credit_stall) begin
      // Whole pipe freezes
      state_d = CREDIT_STALL;
    end else if (redirect_i) begin
      // IF/ID holds the wrong-path slot, so ID/EX must not take it
      if_id_flush_o    = 1'b1;
      id_ex_bubble_o   = 1'b1;
      ex_out_advance_o = 1'b1;
    end else if (load_use) begin
      id_ex_bubble_o   = 1'b1;
      ex_out_advance_o = 1'b1;
      state_d          = LOAD_STALL;
    end else begin
      if_id_advance_o  = 1'b1;
      id_ex_advance_o  = 1'b1;
      ex_out_advance_o = 1'b1;
      in_ready_o       = 1'b1;
    end
  end

  // Last cycle's decision
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

//--- hdl/rv_credit_counter.sv
`timescale 1ns/1ns

module rv_credit_counter import rv_pipe_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    send_i,
  input  logic    credit_return_i,
  output logic    credit_avail_o,
  output credit_t count_o
);

  credit_t count_q;
  logic    take;
  logic    give;

  // A send and a return in the same cycle cancel out
  assign take = send_i && !credit_return_i;
  assign give = credit_return_i && !send_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= CREDITS;
    end else if (take) begin
      // Saturate at zero
      if (count_q != '0) begin
        count_q <= count_q - credit_t'(1);
      end
    end else if (give) begin
      // Never hold more than the consumer granted
      if (count_q != CREDITS) begin
        count_q <= count_q + credit_t'(1);
      end
    end
  end

  assign credit_avail_o = (count_q != '0);
  assign count_o        = count_q;

endmodule

//--- hdl/rv_pipe_data.sv
`timescale 1ns/1ns

module rv_pipe_data #(
  parameter int               WIDTH    = 32,
  parameter logic [WIDTH-1:0] IDLE_VAL = '0
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance_i,
  input  logic             flush_i,
  input  logic             bubble_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o
);

  logic [WIDTH-1:0] data_q;

  // Priority is reset, flush, bubble, advance, then hold
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_q <= IDLE_VAL;
    end else if (flush_i) begin
      // Wrong-path slot is dropped
      data_q <= IDLE_VAL;
    end else if (bubble_i) begin
      // Stage is emptied while the stage above holds
      data_q <= IDLE_VAL;
    end else if (advance_i) begin
      data_q <= data_i;
    end
  end

  assign data_o = data_q;

endmodule

//--- hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // Widths with a meaning of their own
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  credit_t;

  // Credits granted by the downstream consumer after reset
  localparam credit_t CREDITS = 3'd4;

  // Major opcode of the RV32I load group
  localparam logic [6:0] OPC_LOAD = 7'b0000011;

  // Slot as it leaves the fetcher and sits in IF/ID
  typedef struct packed {
    logic  valid;
    xlen_t pc;
    xlen_t instr;
  } fetch_slot_t;

  // Slot after decode, carried through ID/EX and EX/OUT
  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    xlen_t    instr;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     is_load;
  } dec_slot_t;

  localparam fetch_slot_t FETCH_IDLE = '0;
  localparam dec_slot_t   DEC_IDLE   = '0;

  // Hazard unit decision, kept for waveform naming
  typedef enum logic [1:0] {
    RUN,
    LOAD_STALL,
    CREDIT_STALL
  } ctrl_state_t;

  // Register fields sit at fixed positions in every RV32 format
  function automatic dec_slot_t rv_decode(input fetch_slot_t slot);
    dec_slot_t dec;
    dec.valid   = slot.valid;
    dec.pc      = slot.pc;
    dec.instr   = slot.instr;
    dec.rd      = slot.instr[11:7];
    dec.rs1     = slot.instr[19:15];
    dec.rs2     = slot.instr[24:20];
    dec.is_load = (slot.instr[6:0] == OPC_LOAD);
    return dec;
  endfunction

endpackage
